// ==== hw/wb_pkg.sv ====
// Wishbone bus widths
// Address map pages of the peripheral slaves
// Address word with raw and field views
`default_nettype none

package wb_pkg;

	// Bus widths
	localparam int WB_ADR_W = 32;
	localparam int WB_DAT_W = 32;
	localparam int WB_SEL_W = 4;

	// --------------------
	// Address map
	// --------------------
	// Page is the top 15 address bits
	localparam int PAGE_W = 15;
	localparam logic [PAGE_W-1:0] PAGE_TIMER = 15'h7001;
	localparam logic [PAGE_W-1:0] PAGE_GPIO  = 15'h7002;

	// Decoder looks at the page, slaves at the register index
	typedef union packed {
		logic [WB_ADR_W-1:0] raw;
		struct packed {
			logic [PAGE_W-1:0] page;
			logic [11:0]       unused;
			logic [2:0]        reg_idx;
			logic [1:0]        byte_ofs;
		} f;
	} wb_adr_u;

endpackage

`default_nettype wire

// ==== hw/periph_pkg.sv ====
// Timer and GPIO register indices, timer control bits
// Interrupt vector positions and button placement in GPIO
// Hex digit patterns for the seven-segment display
`default_nettype none

package periph_pkg;

	// --------------------
	// Timer registers
	// --------------------
	localparam logic [2:0] REG_TCR0 = 3'd0;
	localparam logic [2:0] REG_CMP0 = 3'd1;
	localparam logic [2:0] REG_CNT0 = 3'd2;
	localparam logic [2:0] REG_TCR1 = 3'd3;
	localparam logic [2:0] REG_CMP1 = 3'd4;
	localparam logic [2:0] REG_CNT1 = 3'd5;

	// TCR bit positions
	localparam int TCR_EN    = 0;
	localparam int TCR_AR    = 1;
	localparam int TCR_IRQEN = 2;
	localparam int TCR_TRIG  = 3;

	// --------------------
	// GPIO registers
	// --------------------
	localparam logic [2:0] REG_GPIO_IN   = 3'd0;
	localparam logic [2:0] REG_GPIO_OUT  = 3'd1;
	localparam logic [2:0] REG_GPIO_OE   = 3'd2;
	localparam logic [2:0] REG_GPIO_MASK = 3'd3;

	// Buttons land on GPIO input bits 11:8
	localparam int BTN_GPIO_LSB = 8;

	// Interrupt vector positions
	localparam int IRQ_UART   = 0;
	localparam int IRQ_TIMER0 = 1;
	localparam int IRQ_GPIO   = 2;
	localparam int IRQ_TIMER1 = 3;

	// Active low segments, a in bit 0 up to g in bit 6
	localparam logic [6:0] SEG_HEX [16] = '{
		7'h40,
		7'h79,
		7'h24,
		7'h30,
		7'h19,
		7'h12,
		7'h02,
		7'h78,
		7'h00,
		7'h10,
		7'h08,
		7'h03,
		7'h46,
		7'h21,
		7'h06,
		7'h0E
	};

endpackage

`default_nettype wire

// ==== hw/wb_decoder.sv ====
// Wishbone address decoder for the timer and GPIO pages
// Slave strobe routing, read data and ack mux
// Local ack for unmapped pages
`timescale 1ns/1ps
`default_nettype none

module wb_decoder (
	input  wire                          clk_i,
	input  wire                          arst_n_i,
	input  wire                          wb_cyc_i,
	input  wire                          wb_stb_i,
	input  wb_pkg::wb_adr_u              wb_adr_i,
	output logic                         timer_stb_o,
	output logic                         gpio_stb_o,
	input  wire  [wb_pkg::WB_DAT_W-1:0]  timer_dat_i,
	input  wire                          timer_ack_i,
	input  wire  [wb_pkg::WB_DAT_W-1:0]  gpio_dat_i,
	input  wire                          gpio_ack_i,
	output logic [wb_pkg::WB_DAT_W-1:0]  wb_dat_o,
	output logic                         wb_ack_o
);
	import wb_pkg::*;

	logic hit_timer;
	logic hit_gpio;
	logic nomap_ack;

	// Page compare
	assign hit_timer = (wb_adr_i.f.page == PAGE_TIMER);
	assign hit_gpio  = (wb_adr_i.f.page == PAGE_GPIO);

	// Strobe goes only to the addressed slave
	assign timer_stb_o = wb_stb_i & hit_timer;
	assign gpio_stb_o  = wb_stb_i & hit_gpio;

	// --------------------
	// Unmapped pages
	// --------------------
	// One-cycle ack so the master never hangs
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			nomap_ack <= 1'b0;
		end else begin
			nomap_ack <= wb_cyc_i & wb_stb_i & ~hit_timer & ~hit_gpio & ~nomap_ack;
		end
	end

	// Data follows whichever slave acks and is zero otherwise
	always_comb begin
		if (timer_ack_i) begin
			wb_dat_o = timer_dat_i;
		end else if (gpio_ack_i) begin
			wb_dat_o = gpio_dat_i;
		end else begin
			wb_dat_o = '0;
		end
	end

	assign wb_ack_o = timer_ack_i | gpio_ack_i | nomap_ack;

	// Only one ack source at a time
	a_one_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0({timer_ack_i, gpio_ack_i, nomap_ack}));

endmodule

`default_nettype wire

// ==== hw/wb_timer.sv ====
// Two-channel compare timer on Wishbone
// Per channel control, compare and counter registers
// One-shot or auto-reload with an interrupt per channel
`timescale 1ns/1ps
`default_nettype none

module wb_timer (
	input  wire                          clk_i,
	input  wire                          arst_n_i,
	input  wire                          wb_cyc_i,
	input  wire                          wb_stb_i,
	input  wire                          wb_we_i,
	input  wb_pkg::wb_adr_u              wb_adr_i,
	input  wire  [wb_pkg::WB_DAT_W-1:0]  wb_dat_i,
	output logic [wb_pkg::WB_DAT_W-1:0]  wb_dat_o,
	output logic                         wb_ack_o,
	output logic [1:0]                   irq_o
);
	import periph_pkg::*;

	// Register index of each channel
	localparam logic [2:0] TCR_IDX [2] = '{REG_TCR0, REG_TCR1};
	localparam logic [2:0] CMP_IDX [2] = '{REG_CMP0, REG_CMP1};
	localparam logic [2:0] CNT_IDX [2] = '{REG_CNT0, REG_CNT1};

	logic [1:0]  en;
	logic [1:0]  ar;
	logic [1:0]  irqen;
	logic [1:0]  trig;
	logic [31:0] cmp [2];
	logic [31:0] cnt [2];
	logic [31:0] cnt_inc [2];
	logic        wr;

	// Write lands on the edge that raises ack
	assign wr = wb_cyc_i & wb_stb_i & wb_we_i & ~wb_ack_o;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= wb_cyc_i & wb_stb_i & ~wb_ack_o;
		end
	end

	always_comb begin
		for (int ch = 0; ch < 2; ch++) begin
			cnt_inc[ch] = cnt[ch] + 32'd1;
		end
	end

	// --------------------
	// Channel state
	// --------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			en    <= '0;
			ar    <= '0;
			irqen <= '0;
			trig  <= '0;
			for (int ch = 0; ch < 2; ch++) begin
				cmp[ch] <= '0;
				cnt[ch] <= '0;
			end
		end else begin
			for (int ch = 0; ch < 2; ch++) begin
				// Count and compare
				if (en[ch]) begin
					if (cnt_inc[ch] == cmp[ch]) begin
						trig[ch] <= 1'b1;
						if (ar[ch]) begin
							cnt[ch] <= '0;
						end else begin
							// One-shot stops on the compare value
							cnt[ch] <= cnt_inc[ch];
							en[ch]  <= 1'b0;
						end
					end else begin
						cnt[ch] <= cnt_inc[ch];
					end
				end
				// Bus writes take priority over counting
				if (wr && wb_adr_i.f.reg_idx == TCR_IDX[ch]) begin
					en[ch]    <= wb_dat_i[TCR_EN];
					ar[ch]    <= wb_dat_i[TCR_AR];
					irqen[ch] <= wb_dat_i[TCR_IRQEN];
					trig[ch]  <= 1'b0;
				end
				if (wr && wb_adr_i.f.reg_idx == CMP_IDX[ch]) begin
					cmp[ch] <= wb_dat_i;
				end
				if (wr && wb_adr_i.f.reg_idx == CNT_IDX[ch]) begin
					cnt[ch] <= wb_dat_i;
				end
			end
		end
	end

	// Read mux with unused indices reading zero
	always_comb begin
		wb_dat_o = '0;
		for (int ch = 0; ch < 2; ch++) begin
			if (wb_adr_i.f.reg_idx == TCR_IDX[ch]) begin
				wb_dat_o[TCR_EN]    = en[ch];
				wb_dat_o[TCR_AR]    = ar[ch];
				wb_dat_o[TCR_IRQEN] = irqen[ch];
				wb_dat_o[TCR_TRIG]  = trig[ch];
			end
			if (wb_adr_i.f.reg_idx == CMP_IDX[ch]) begin
				wb_dat_o = cmp[ch];
			end
			if (wb_adr_i.f.reg_idx == CNT_IDX[ch]) begin
				wb_dat_o = cnt[ch];
			end
		end
	end

	assign irq_o = trig & irqen;

	// Auto-reload wraps before it reaches the compare
	a_ar_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(en[1] && ar[1] && cmp[1] != 0 && cnt[1] < cmp[1] && !wr)
		|=> (cnt[1] < cmp[1]));

endmodule

`default_nettype wire

// ==== hw/wb_gpio.sv ====
// Wishbone GPIO with input, output, output-enable and mask
// Byte-wise register writes, sampled inputs
// Level interrupt from masked inputs
`timescale 1ns/1ps
`default_nettype none

module wb_gpio (
	input  wire                          clk_i,
	input  wire                          arst_n_i,
	input  wire                          wb_cyc_i,
	input  wire                          wb_stb_i,
	input  wire                          wb_we_i,
	input  wb_pkg::wb_adr_u              wb_adr_i,
	input  wire  [wb_pkg::WB_DAT_W-1:0]  wb_dat_i,
	input  wire  [wb_pkg::WB_SEL_W-1:0]  wb_sel_i,
	output logic [wb_pkg::WB_DAT_W-1:0]  wb_dat_o,
	output logic                         wb_ack_o,
	input  wire  [31:0]                  gpio_in_i,
	output logic [31:0]                  gpio_out_o,
	output logic [31:0]                  gpio_oe_o,
	output logic                         irq_o
);
	import periph_pkg::*;

	logic [31:0] in_q;
	logic [31:0] mask_q;
	logic        wr;

	// Byte lanes with sel set take the new data
	function automatic logic [31:0] byte_merge(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	assign wr = wb_cyc_i & wb_stb_i & wb_we_i & ~wb_ack_o;

	// Input sample stage
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			in_q <= '0;
		end else begin
			in_q <= gpio_in_i;
		end
	end

	// --------------------
	// Registers
	// --------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_ack_o   <= 1'b0;
			gpio_out_o <= '0;
			gpio_oe_o  <= '0;
			mask_q     <= '0;
		end else begin
			wb_ack_o <= wb_cyc_i & wb_stb_i & ~wb_ack_o;
			if (wr && wb_adr_i.f.reg_idx == REG_GPIO_OUT)
				gpio_out_o <= byte_merge(gpio_out_o, wb_dat_i, wb_sel_i);
			if (wr && wb_adr_i.f.reg_idx == REG_GPIO_OE)
				gpio_oe_o <= byte_merge(gpio_oe_o, wb_dat_i, wb_sel_i);
			if (wr && wb_adr_i.f.reg_idx == REG_GPIO_MASK)
				mask_q <= byte_merge(mask_q, wb_dat_i, wb_sel_i);
		end
	end

	always_comb begin
		case (wb_adr_i.f.reg_idx)
			REG_GPIO_IN:   wb_dat_o = in_q;
			REG_GPIO_OUT:  wb_dat_o = gpio_out_o;
			REG_GPIO_OE:   wb_dat_o = gpio_oe_o;
			REG_GPIO_MASK: wb_dat_o = mask_q;
			default:       wb_dat_o = '0;
		endcase
	end

	// Any enabled input high
	assign irq_o = |(in_q & mask_q);

endmodule

`default_nettype wire

// ==== hw/sevenseg_scan.sv ====
// Four-digit multiplexed seven-segment scanner
// Shows a 16-bit value as hex with digit 0 on the low nibble
`timescale 1ns/1ps
`default_nettype none

module sevenseg_scan #(
	parameter int clk_freq = 50_000_000,
	parameter int scan_hz  = 1000
) (
	input  wire         clk_i,
	input  wire         arst_n_i,
	input  wire  [15:0] value_i,
	output logic [6:0]  seg_o,
	output logic [3:0]  an_o
);
	import periph_pkg::*;

	// Cycles per digit
	localparam int DIV   = clk_freq / scan_hz;
	localparam int DIV_W = $clog2(DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic [1:0]       digit;

	// --------------------
	// Digit stepping
	// --------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			div_cnt <= '0;
			digit   <= '0;
		end else if (div_cnt == DIV_W'(DIV - 1)) begin
			div_cnt <= '0;
			digit   <= digit + 2'd1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Anode and pattern registered together and all dark in reset
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			an_o  <= 4'hF;
			seg_o <= 7'h7F;
		end else begin
			an_o  <= ~(4'b0001 << digit);
			seg_o <= SEG_HEX[value_i[4*digit +: 4]];
		end
	end

endmodule

`default_nettype wire

// ==== hw/board_io.sv ====
// Board glue: button reset with synchronized release
// LED select between GPIO and debug set
// Button inputs into GPIO
`timescale 1ns/1ps
`default_nettype none

module board_io (
	input  wire         clk_i,
	input  wire         arst_n_i,
	input  wire  [3:0]  btn_i,
	input  wire  [7:0]  sw_i,
	input  wire  [7:0]  gpio_out_i,
	input  wire  [1:0]  timer_irq_i,
	input  wire         gpio_irq_i,
	input  wire         wb_cyc_i,
	input  wire         wb_stb_i,
	input  wire         wb_ack_i,
	output logic        rst_n_o,
	output logic [7:0]  led_o,
	output logic [31:0] gpio_in_o
);
	import periph_pkg::*;

	logic       rst_req_n;
	logic [1:0] rst_sync;

	// Board reset or btn 0 while sw 1 is off
	assign rst_req_n = arst_n_i & ~(btn_i[0] & ~sw_i[1]);

	// --------------------
	// Reset synchronizer
	// --------------------
	// Asserts at once, releases two edges later
	always_ff @(posedge clk_i or negedge rst_req_n) begin
		if (!rst_req_n) begin
			rst_sync <= 2'b00;
		end else begin
			rst_sync <= {rst_sync[0], 1'b1};
		end
	end

	assign rst_n_o = rst_sync[1];

	// Debug set when sw 1 is off
	always_comb begin
		if (sw_i[1]) begin
			led_o = gpio_out_i;
		end else begin
			led_o = {timer_irq_i[1], gpio_irq_i, timer_irq_i[0], ~rst_n_o,
				wb_cyc_i, wb_stb_i, wb_ack_i, 1'b0};
		end
	end

	// Buttons only reach GPIO with sw 1 on
	always_comb begin
		gpio_in_o = '0;
		if (sw_i[1]) gpio_in_o[BTN_GPIO_LSB +: 4] = btn_i;
	end

endmodule

`default_nettype wire

// ==== hw/soc_periph_top.sv ====
// Peripheral subsystem top: decoder, timer, GPIO
// Seven-segment scanner, board glue
// Active low interrupt vector for the CPU
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top #(
	parameter int clk_freq = 50_000_000,
	parameter int scan_hz  = 1000
) (
	input  wire                          clk_i,
	input  wire                          arst_n_i,
	input  wire                          wb_cyc_i,
	input  wire                          wb_stb_i,
	input  wire                          wb_we_i,
	input  wire  [wb_pkg::WB_ADR_W-1:0]  wb_adr_i,
	input  wire  [wb_pkg::WB_DAT_W-1:0]  wb_dat_i,
	input  wire  [wb_pkg::WB_SEL_W-1:0]  wb_sel_i,
	output logic [wb_pkg::WB_DAT_W-1:0]  wb_dat_o,
	output logic                         wb_ack_o,
	input  wire  [3:0]                   btn_i,
	input  wire  [7:0]                   sw_i,
	output logic [7:0]                   led_o,
	output logic [6:0]                   seg_o,
	output logic [3:0]                   an_o,
	output logic [31:0]                  irq_n_o
);
	import wb_pkg::*;
	import periph_pkg::*;

	wb_adr_u              bus_adr;
	logic                 rst_n;
	logic                 timer_stb;
	logic                 gpio_stb;
	logic [WB_DAT_W-1:0]  timer_dat;
	logic [WB_DAT_W-1:0]  gpio_dat;
	logic                 timer_ack;
	logic                 gpio_ack;
	logic [1:0]           timer_irq;
	logic                 gpio_irq;
	logic [31:0]          gpio_in;
	logic [31:0]          gpio_out;

	assign bus_adr.raw = wb_adr_i;

	// --------------------
	// Bus
	// --------------------
	wb_decoder dec0 (
		.clk_i(clk_i), .arst_n_i(rst_n),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_adr_i(bus_adr),
		.timer_stb_o(timer_stb), .gpio_stb_o(gpio_stb),
		.timer_dat_i(timer_dat), .timer_ack_i(timer_ack),
		.gpio_dat_i(gpio_dat), .gpio_ack_i(gpio_ack),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o)
	);

	wb_timer timer0 (
		.clk_i(clk_i), .arst_n_i(rst_n),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(timer_stb), .wb_we_i(wb_we_i),
		.wb_adr_i(bus_adr), .wb_dat_i(wb_dat_i),
		.wb_dat_o(timer_dat), .wb_ack_o(timer_ack), .irq_o(timer_irq)
	);

	// Output enables have no pad here
	wb_gpio gpio0 (
		.clk_i(clk_i), .arst_n_i(rst_n),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(gpio_stb), .wb_we_i(wb_we_i),
		.wb_adr_i(bus_adr), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
		.wb_dat_o(gpio_dat), .wb_ack_o(gpio_ack),
		.gpio_in_i(gpio_in), .gpio_out_o(gpio_out), .gpio_oe_o(), .irq_o(gpio_irq)
	);

	// Display shows GPIO out 31:16
	sevenseg_scan #(.clk_freq(clk_freq), .scan_hz(scan_hz)) seg0 (
		.clk_i(clk_i), .arst_n_i(rst_n),
		.value_i(gpio_out[31:16]), .seg_o(seg_o), .an_o(an_o)
	);

	board_io io0 (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.btn_i(btn_i), .sw_i(sw_i), .gpio_out_i(gpio_out[7:0]),
		.timer_irq_i(timer_irq), .gpio_irq_i(gpio_irq),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_ack_i(wb_ack_o),
		.rst_n_o(rst_n), .led_o(led_o), .gpio_in_o(gpio_in)
	);

	// Interrupt vector, unused lines idle high
	always_comb begin
		irq_n_o             = '1;
		irq_n_o[IRQ_UART]   = 1'b1;
		irq_n_o[IRQ_TIMER0] = ~timer_irq[0];
		irq_n_o[IRQ_GPIO]   = ~gpio_irq;
		irq_n_o[IRQ_TIMER1] = ~timer_irq[1];
	end

endmodule

`default_nettype wire

// ==== sim/tb_soc.sv ====
// Testbench for the peripheral subsystem top
// Table of bus operations and expected values, applied in a loop
// LFSR data, display scan and button reset checks
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

	// --------------------
	// Constants
	// --------------------
	localparam int RST_CYCLES = 10;
	localparam int SEG_CYCLES = 60;
	localparam int CMP0_N     = 20;
	localparam int CMP1_N     = 12;
	localparam logic [15:0] SEED = 16'd36242;

	// Pages 0x7001 and 0x7002 sit in the top 15 bits with the register index at bit 2
	localparam logic [31:0] A_TCR0  = 32'hE002_0000;
	localparam logic [31:0] A_CNT0  = 32'hE002_0008;
	localparam logic [31:0] A_CMP0  = 32'hE002_0004;
	localparam logic [31:0] A_TCR1  = 32'hE002_000C;
	localparam logic [31:0] A_CMP1  = 32'hE002_0010;
	localparam logic [31:0] A_CNT1  = 32'hE002_0014;
	localparam logic [31:0] A_IN    = 32'hE004_0000;
	localparam logic [31:0] A_OUT   = 32'hE004_0004;
	localparam logic [31:0] A_OE    = 32'hE004_0008;
	localparam logic [31:0] A_MASK  = 32'hE004_000C;
	localparam logic [31:0] A_NOMAP = 32'h0000_1000;

	// Hex digits on an active low display with a in bit 0
	localparam logic [6:0] SEG_EXP [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
	};

	typedef enum logic [3:0] {
		OP_WR, OP_RD, OP_WRND, OP_POLL, OP_ARCHK, OP_IRQ, OP_LED, OP_SEG, OP_WAIT
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  sel;
		logic [7:0]  sw;
		logic [3:0]  btn;
		logic [31:0] exp_v;
	} row_t;

	localparam int NROWS = 36;
	localparam int TIMEOUT = 20 * (NROWS + CMP0_N + CMP1_N) + SEG_CYCLES + RST_CYCLES;

	// --------------------
	// Stimulus table
	// --------------------
	// op, addr, data, sel, sw, btn, expected
	localparam row_t TABLE [NROWS] = '{
		// GPIO byte writes, LEDs, unmapped page
		'{OP_WRND,  A_OUT,   32'h0,      4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_WRND,  A_OUT,   32'h0,      4'h5, 8'h02, 4'h0, 32'h0},
		'{OP_WRND,  A_OUT,   32'h0,      4'hA, 8'h02, 4'h0, 32'h0},
		'{OP_WRND,  A_OUT,   32'h0,      4'h3, 8'h02, 4'h0, 32'h0},
		'{OP_WR,    A_OE,    32'hFFFF,   4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_RD,    A_OE,    32'h0,      4'hF, 8'h02, 4'h0, 32'h0000_FFFF},
		'{OP_RD,    A_NOMAP, 32'h0,      4'hF, 8'h02, 4'h0, 32'h0},
		// Buttons 1 and 2 held with the mask on button 2
		'{OP_WR,    A_MASK,  32'h400,    4'hF, 8'h02, 4'h6, 32'h0},
		'{OP_RD,    A_IN,    32'h0,      4'hF, 8'h02, 4'h6, 32'h0000_0600},
		'{OP_IRQ,   32'h0,   32'h0,      4'h0, 8'h02, 4'h6, 32'hFFFF_FFFB},
		'{OP_RD,    A_IN,    32'h0,      4'hF, 8'h00, 4'h6, 32'h0},
		'{OP_IRQ,   32'h0,   32'h0,      4'h0, 8'h00, 4'h6, 32'hFFFF_FFFF},
		// Channel 0 one-shot
		'{OP_WR,    A_CMP0,  CMP0_N,     4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_WR,    A_CNT0,  32'h0,      4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_WR,    A_TCR0,  32'h5,      4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_POLL,  A_TCR0,  32'h8,      4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_RD,    A_CNT0,  32'h0,      4'hF, 8'h02, 4'h0, CMP0_N},
		'{OP_RD,    A_TCR0,  32'h0,      4'hF, 8'h02, 4'h0, 32'h0000_000C},
		'{OP_IRQ,   32'h0,   32'h0,      4'h0, 8'h02, 4'h0, 32'hFFFF_FFFD},
		'{OP_WR,    A_TCR0,  32'h2,      4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_IRQ,   32'h0,   32'h0,      4'h0, 8'h02, 4'h0, 32'hFFFF_FFFF},
		// Channel 1 auto-reload
		'{OP_WR,    A_CMP1,  CMP1_N,     4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_WR,    A_CNT1,  32'h0,      4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_WR,    A_TCR1,  32'h7,      4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_ARCHK, A_CNT1,  32'd8,      4'hF, 8'h02, 4'h0, CMP1_N},
		'{OP_POLL,  A_TCR1,  32'h8,      4'hF, 8'h02, 4'h0, 32'h0},
		'{OP_IRQ,   32'h0,   32'h0,      4'h0, 8'h02, 4'h0, 32'hFFFF_FFF7},
		'{OP_RD,    A_TCR1,  32'h0,      4'hF, 8'h02, 4'h0, 32'h0000_000F},
		// Display of OUT 31:16
		'{OP_WRND,  A_OUT,   32'h0,      4'hC, 8'h02, 4'h0, 32'h0},
		'{OP_SEG,   32'h0,   SEG_CYCLES, 4'h0, 8'h02, 4'h0, 32'h0},
		// Button reset with debug LEDs
		'{OP_LED,   32'h0,   32'h0,      4'h0, 8'h00, 4'h1, 32'h0000_0010},
		'{OP_WAIT,  32'h0,   32'd3,      4'h0, 8'h00, 4'h0, 32'h0},
		'{OP_RD,    A_OUT,   32'h0,      4'hF, 8'h00, 4'h0, 32'h0},
		'{OP_RD,    A_TCR0,  32'h0,      4'hF, 8'h00, 4'h0, 32'h0},
		'{OP_LED,   32'h0,   32'h0,      4'h0, 8'h00, 4'h0, 32'h0},
		'{OP_IRQ,   32'h0,   32'h0,      4'h0, 8'h00, 4'h0, 32'hFFFF_FFFF}
	};

	logic        clk_i;
	logic        arst_n_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [31:0] wb_adr_i;
	logic [31:0] wb_dat_i;
	logic [3:0]  wb_sel_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;
	logic [3:0]  btn_i;
	logic [7:0]  sw_i;
	logic [7:0]  led_o;
	logic [6:0]  seg_o;
	logic [3:0]  an_o;
	logic [31:0] irq_n_o;

	logic [15:0] lfsr;
	logic [31:0] out_model;
	int          cycles = 0;

	soc_periph_top #(.clk_freq(1000), .scan_hz(100)) uut (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_sel_i(wb_sel_i),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.btn_i(btn_i), .sw_i(sw_i), .led_o(led_o),
		.seg_o(seg_o), .an_o(an_o), .irq_n_o(irq_n_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// --------------------
	// Helpers
	// --------------------
	task automatic stop_run();
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got,
			input logic [31:0] exp_v);
		assert (got === exp_v) else begin
			$display("Mismatch %s got 0x%08h expected 0x%08h", name, got, exp_v);
			stop_run();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("Error: %s", what);
			stop_run();
		end
	endtask

	// Galois LFSR on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	task automatic rand_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			w = {w[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
	endtask

	// Single Wishbone access; ack expected one cycle after the request
	task automatic bus_cycle(input logic we, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] sel, output logic [31:0] rdata);
		int waits;
		waits = 0;
		@(posedge clk_i);
		#1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = addr;
		wb_dat_i = data;
		wb_sel_i = sel;
		do begin
			@(posedge clk_i);
			#1;
			waits++;
		end while (!wb_ack_o);
		rdata    = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		check_eq("ack latency", waits, 32'd1);
	endtask

	// One table row; switches and buttons settle for a cycle first
	task automatic run_row(input row_t r);
		logic [31:0] rd;
		logic [31:0] w;
		logic [3:0]  seen;
		sw_i  = r.sw;
		btn_i = r.btn;
		@(posedge clk_i);
		#1;
		case (r.op)
			OP_WR: bus_cycle(1'b1, r.addr, r.data, r.sel, rd);
			OP_RD: begin
				bus_cycle(1'b0, r.addr, 32'h0, r.sel, rd);
				check_eq("wb_dat_o", rd, r.exp_v);
			end
			OP_WRND: begin
				rand_word(w);
				bus_cycle(1'b1, r.addr, w, r.sel, rd);
				// Only selected byte lanes change
				for (int b = 0; b < 4; b++) begin
					if (r.sel[b]) out_model[8*b +: 8] = w[8*b +: 8];
				end
				bus_cycle(1'b0, r.addr, 32'h0, 4'hF, rd);
				check_eq("wb_dat_o", rd, out_model);
				if (r.sw[1]) begin
					check_eq("led_o", {24'h0, led_o}, {24'h0, out_model[7:0]});
				end
			end
			OP_POLL: begin
				rd = '0;
				while ((rd & r.data) == 0) begin
					bus_cycle(1'b0, r.addr, 32'h0, 4'hF, rd);
				end
			end
			OP_ARCHK: begin
				repeat (r.data) begin
					bus_cycle(1'b0, r.addr, 32'h0, 4'hF, rd);
					check_true(rd <= r.exp_v, "auto-reload counter passed its compare");
				end
			end
			OP_IRQ: check_eq("irq_n_o", irq_n_o, r.exp_v);
			OP_LED: check_eq("led_o", {24'h0, led_o}, r.exp_v);
			OP_SEG: begin
				seen = '0;
				repeat (r.data) begin
					@(posedge clk_i);
					#1;
					check_true($countones(an_o) == 3, "an_o does not select a single digit");
					for (int k = 0; k < 4; k++) begin
						if (!an_o[k]) begin
							seen[k] = 1'b1;
							check_eq("seg_o", {25'h0, seg_o},
								{25'h0, SEG_EXP[out_model[16 + 4*k +: 4]]});
						end
					end
				end
				check_true(seen == 4'hF, "not every digit was lit during the scan");
			end
			OP_WAIT: begin
				repeat (r.data) begin
					@(posedge clk_i);
					#1;
				end
			end
			default: check_true(1'b0, "unknown table operation");
		endcase
	endtask

	// Run limit
	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Error: run did not finish within %0d cycles", TIMEOUT);
			stop_run();
		end
	end

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		arst_n_i  = 1'b0;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_adr_i  = '0;
		wb_dat_i  = '0;
		wb_sel_i  = '0;
		btn_i     = '0;
		sw_i      = 8'h02;
		lfsr      = SEED;
		out_model = '0;
		repeat (RST_CYCLES) @(posedge clk_i);
		#1;
		// Everything idle while in reset
		check_eq("irq_n_o", irq_n_o, 32'hFFFF_FFFF);
		check_eq("an_o", {28'h0, an_o}, 32'hF);
		check_eq("wb_ack_o", {31'h0, wb_ack_o}, 32'h0);
		arst_n_i = 1'b1;
		// Synchronizer release
		repeat (3) @(posedge clk_i);
		#1;
		for (int i = 0; i < NROWS; i++) begin
			run_row(TABLE[i]);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
hw/wb_pkg.sv
hw/periph_pkg.sv
hw/wb_decoder.sv
hw/wb_timer.sv
hw/wb_gpio.sv
hw/sevenseg_scan.sv
hw/board_io.sv
hw/soc_periph_top.sv
sim/tb_soc.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log &&
verilator --binary --timing --assert -f src.f --top-module tb_soc \
	-Mdir obj_dir -o tb_soc > build.log 2>&1 &&
./obj_dir/tb_soc > sim.log 2>&1

cat sim.log 2>/dev/null || cat build.log

grep -qx '\*\* PASS \*\*' sim.log 2>/dev/null &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }
